/* src/fifo_cfg_pkg.sv */
// fifo geometry and flag thresholds, referenced by scoped names from rtl and testbench
`default_nettype none

package fifo_cfg_pkg;

   // --------------------
   // geometry
   // --------------------
   localparam int DATA_W = 8;       // data word width
   localparam int DEPTH  = 16;      // number of entries
   localparam int ADDR_W = 4;       // pointer width, log2 of DEPTH
   localparam int CNT_W  = ADDR_W + 1;   // holds 0 through DEPTH

   // pointer and level values at the top of the range
   localparam logic [ADDR_W-1:0] ADDR_LAST = ADDR_W'(DEPTH - 1);   // last slot, wraps after
   localparam logic [CNT_W-1:0]  LVL_FULL  = CNT_W'(DEPTH);        // level when full

   // --------------------
   // thresholds
   // --------------------
   // almost full holds at or above this level
   localparam logic [CNT_W-1:0] AFULL_VAL  = CNT_W'(14);
   // almost empty holds at or below this level
   localparam logic [CNT_W-1:0] AEMPTY_VAL = CNT_W'(2);

endpackage

`default_nettype wire

/* src/fifo_state_pkg.sv */
// state codes of the fifo flag state machine, shared by the fsm and the bound checks
`default_nettype none

package fifo_state_pkg;

   // --------------------
   // flag fsm encoding
   // --------------------
   localparam int ST_W = 2;   // state register width

   localparam logic [ST_W-1:0] ST_EMPTY   = 2'd0;   // no words stored
   localparam logic [ST_W-1:0] ST_PARTIAL = 2'd1;   // 1 .. DEPTH-1 words
   localparam logic [ST_W-1:0] ST_FULL    = 2'd2;   // DEPTH words, writes refused

   // 2'd3 unused, fsm falls back to empty

endpackage

`default_nettype wire

/* src/fifo_ctrl_if.sv */
// accepted operations and occupancy shared by the fifo flag fsm, level counter and ram
`timescale 1ns/1ps
`default_nettype none

interface fifo_ctrl_if;

   // accepted operations, gated by the fsm
   logic wr_ok;   // write taken this cycle
   logic rd_ok;   // read taken this cycle

   // occupancy, owned by the counter
   logic [fifo_cfg_pkg::CNT_W-1:0] level;        // registered count
   logic [fifo_cfg_pkg::CNT_W-1:0] level_next;   // count after the coming edge

   // --------------------
   // views
   // --------------------
   modport fsm_mp (
      output wr_ok,
      output rd_ok,
      input  level,
      input  level_next
   );

   modport cnt_mp (
      input  wr_ok,
      input  rd_ok,
      output level,
      output level_next
   );

   modport ram_mp (
      input  wr_ok,
      input  rd_ok
   );

endinterface

`default_nettype wire

/* src/fifo_flag_fsm.sv */
// flag fsm of the sync fifo: gates we/re requests and registers status flags and strobes
`timescale 1ns/1ps
`default_nettype none

module fifo_flag_fsm (
   input  wire          pos_clk,
   input  wire          aresetn,
   input  wire          we_i,          // write request strobe
   input  wire          re_i,          // read request strobe
   fifo_ctrl_if.fsm_mp  ctrl,
   output logic         full_o,
   output logic         afull_o,
   output logic         empty_o,
   output logic         aempty_o,
   output logic         wack_o,        // write taken last edge
   output logic         dvld_o,        // rdata_o valid
   output logic         overflow_o,    // write refused while full
   output logic         underflow_o    // read refused while empty
);

   logic [fifo_state_pkg::ST_W-1:0] state;       // current occupancy class
   logic [fifo_state_pkg::ST_W-1:0] state_nxt;   // class after this edge

   // --------------------
   // request gating
   // --------------------
   // refused requests never reach the counter or the ram
   always_comb begin
      ctrl.wr_ok = we_i & (state != fifo_state_pkg::ST_FULL);
      ctrl.rd_ok = re_i & (state != fifo_state_pkg::ST_EMPTY);
   end

   // --------------------
   // next state
   // --------------------
   // level_next already reflects the gated operations
   always_comb begin
      state_nxt = state;   // hold by default
      case (state)
         fifo_state_pkg::ST_EMPTY: begin
            if (ctrl.level_next != '0) begin
               state_nxt = fifo_state_pkg::ST_PARTIAL;   // first word in
            end
         end
         fifo_state_pkg::ST_PARTIAL: begin
            if (ctrl.level_next == '0) begin
               state_nxt = fifo_state_pkg::ST_EMPTY;     // last word out
            end else if (ctrl.level_next == fifo_cfg_pkg::LVL_FULL) begin
               state_nxt = fifo_state_pkg::ST_FULL;      // last slot taken
            end
         end
         fifo_state_pkg::ST_FULL: begin
            if (ctrl.level_next != fifo_cfg_pkg::LVL_FULL) begin
               state_nxt = fifo_state_pkg::ST_PARTIAL;   // a read freed a slot
            end
         end
         default: begin
            state_nxt = fifo_state_pkg::ST_EMPTY;        // illegal code recovers
         end
      endcase
   end

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         state <= fifo_state_pkg::ST_EMPTY;
      end else begin
         state <= state_nxt;
      end
   end

   // --------------------
   // status flags
   // --------------------
   // all flags follow the occupancy after this edge
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         full_o   <= 1'b0;
         afull_o  <= 1'b0;
         empty_o  <= 1'b1;   // idle fifo is empty
         aempty_o <= 1'b1;
      end else begin
         full_o   <= (state_nxt == fifo_state_pkg::ST_FULL);
         empty_o  <= (state_nxt == fifo_state_pkg::ST_EMPTY);
         afull_o  <= (ctrl.level_next >= fifo_cfg_pkg::AFULL_VAL);
         aempty_o <= (ctrl.level_next <= fifo_cfg_pkg::AEMPTY_VAL);
      end
   end

   // --------------------
   // strobes
   // --------------------
   // one cycle each, one cycle after the request
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wack_o      <= 1'b0;
         dvld_o      <= 1'b0;
         overflow_o  <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         wack_o      <= ctrl.wr_ok;
         dvld_o      <= ctrl.rd_ok;   // matches the ram read register
         overflow_o  <= we_i & (state == fifo_state_pkg::ST_FULL);
         underflow_o <= re_i & (state == fifo_state_pkg::ST_EMPTY);
      end
   end

endmodule

`default_nettype wire

/* src/fifo_level_counter.sv */
// occupancy counter of the sync fifo, up on an accepted write and down on an accepted read
`timescale 1ns/1ps
`default_nettype none

module fifo_level_counter (
   input  wire                              pos_clk,
   input  wire                              aresetn,
   fifo_ctrl_if.cnt_mp                      ctrl,
   output logic [fifo_cfg_pkg::CNT_W-1:0]   level_o   // words stored
);

   // --------------------
   // next value
   // --------------------
   // write and read together cancel out
   always_comb begin
      case ({ctrl.wr_ok, ctrl.rd_ok})
         2'b10:   ctrl.level_next = ctrl.level + 1'b1;   // write alone
         2'b01:   ctrl.level_next = ctrl.level - 1'b1;   // read alone
         default: ctrl.level_next = ctrl.level;          // idle or both
      endcase
   end

   // --------------------
   // count register
   // --------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         ctrl.level <= '0;
      end else begin
         ctrl.level <= ctrl.level_next;
      end
   end

   assign level_o = ctrl.level;   // the fsm never lets it pass DEPTH

endmodule

`default_nettype wire

/* src/fifo_ram.sv */
// storage array of the sync fifo with wrapping pointers and a registered read port
`timescale 1ns/1ps
`default_nettype none

module fifo_ram (
   input  wire                               pos_clk,
   input  wire                               aresetn,
   fifo_ctrl_if.ram_mp                       ctrl,
   input  wire  [fifo_cfg_pkg::DATA_W-1:0]   wdata_i,
   output logic [fifo_cfg_pkg::DATA_W-1:0]   rdata_o   // held until the next read
);

   logic [fifo_cfg_pkg::DATA_W-1:0] mem [fifo_cfg_pkg::DEPTH];   // word storage
   logic [fifo_cfg_pkg::ADDR_W-1:0] wr_ptr;   // next slot to write
   logic [fifo_cfg_pkg::ADDR_W-1:0] rd_ptr;   // oldest stored word

   // --------------------
   // pointers
   // --------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (ctrl.wr_ok) begin
            if (wr_ptr == fifo_cfg_pkg::ADDR_LAST) begin
               wr_ptr <= '0;   // wrap at depth
            end else begin
               wr_ptr <= wr_ptr + 1'b1;
            end
         end
         if (ctrl.rd_ok) begin
            if (rd_ptr == fifo_cfg_pkg::ADDR_LAST) begin
               rd_ptr <= '0;
            end else begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end
      end
   end

   // --------------------
   // array ports
   // --------------------
   always_ff @(posedge pos_clk) begin
      if (ctrl.wr_ok) begin
         mem[wr_ptr] <= wdata_i;
      end
   end

   // read register, loads only on an accepted read
   always_ff @(posedge pos_clk) begin
      if (ctrl.rd_ok) begin
         rdata_o <= mem[rd_ptr];   // same edge as dvld
      end
   end

endmodule

`default_nettype wire

/* src/sync_fifo.sv */
// top level of the 16 x 8 single-clock fifo, instantiate this with plain ports
`timescale 1ns/1ps
`default_nettype none

module sync_fifo (
   input  wire                               pos_clk,
   input  wire                               aresetn,
   input  wire                               we_i,        // write strobe
   input  wire                               re_i,        // read strobe
   input  wire  [fifo_cfg_pkg::DATA_W-1:0]   wdata_i,
   output logic [fifo_cfg_pkg::DATA_W-1:0]   rdata_o,
   output logic                              full_o,
   output logic                              afull_o,
   output logic                              empty_o,
   output logic                              aempty_o,
   output logic                              wack_o,
   output logic                              dvld_o,
   output logic                              overflow_o,
   output logic                              underflow_o,
   output logic [fifo_cfg_pkg::CNT_W-1:0]    level_o      // words stored
);

   // shared control between fsm, counter and ram
   fifo_ctrl_if u_ctrl_if ();

   // --------------------
   // flag fsm
   // --------------------
   fifo_flag_fsm u_flag_fsm (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .we_i        (we_i),
      .re_i        (re_i),
      .ctrl        (u_ctrl_if.fsm_mp),
      .full_o      (full_o),
      .afull_o     (afull_o),
      .empty_o     (empty_o),
      .aempty_o    (aempty_o),
      .wack_o      (wack_o),
      .dvld_o      (dvld_o),
      .overflow_o  (overflow_o),
      .underflow_o (underflow_o)
   );

   // --------------------
   // occupancy
   // --------------------
   fifo_level_counter u_level_counter (
      .pos_clk (pos_clk),
      .aresetn (aresetn),
      .ctrl    (u_ctrl_if.cnt_mp),
      .level_o (level_o)
   );

   // --------------------
   // storage
   // --------------------
   fifo_ram u_ram (
      .pos_clk (pos_clk),
      .aresetn (aresetn),
      .ctrl    (u_ctrl_if.ram_mp),
      .wdata_i (wdata_i),
      .rdata_o (rdata_o)
   );

endmodule

`default_nettype wire

/* tests/sync_fifo_props.sv */
// flag, strobe and level rules of the sync fifo that the testbench binds into sync_fifo
`timescale 1ns/1ps
`default_nettype none

module sync_fifo_props (
   input wire                             pos_clk,
   input wire                             aresetn,
   input wire                             we_i,
   input wire                             re_i,
   input wire                             full_i,
   input wire                             afull_i,
   input wire                             empty_i,
   input wire                             aempty_i,
   input wire                             wack_i,
   input wire                             dvld_i,
   input wire                             overflow_i,
   input wire                             underflow_i,
   input wire [fifo_cfg_pkg::CNT_W-1:0]   level_i
);

   int fail_cnt = 0;   // failed assertions so far
   logic [fifo_state_pkg::ST_W-1:0] lvl_cls;   // occupancy class seen from the level

   always_comb begin
      if (level_i == '0) begin
         lvl_cls = fifo_state_pkg::ST_EMPTY;
      end else if (level_i == fifo_cfg_pkg::LVL_FULL) begin
         lvl_cls = fifo_state_pkg::ST_FULL;
      end else begin
         lvl_cls = fifo_state_pkg::ST_PARTIAL;
      end
   end

   // --------------------
   // flags against level
   // --------------------
   a_full: assert property (@(posedge pos_clk) disable iff (!aresetn)
      full_i == (lvl_cls == fifo_state_pkg::ST_FULL))
      else begin
         $error("full_o disagrees with level_o");
         fail_cnt = fail_cnt + 1;
      end
   a_empty: assert property (@(posedge pos_clk) disable iff (!aresetn)
      empty_i == (lvl_cls == fifo_state_pkg::ST_EMPTY))
      else begin
         $error("empty_o disagrees with level_o");
         fail_cnt = fail_cnt + 1;
      end
   a_afull: assert property (@(posedge pos_clk) disable iff (!aresetn)
      afull_i == (level_i >= fifo_cfg_pkg::AFULL_VAL))
      else begin
         $error("afull_o disagrees with level_o");
         fail_cnt = fail_cnt + 1;
      end
   a_aempty: assert property (@(posedge pos_clk) disable iff (!aresetn)
      aempty_i == (level_i <= fifo_cfg_pkg::AEMPTY_VAL))
      else begin
         $error("aempty_o disagrees with level_o");
         fail_cnt = fail_cnt + 1;
      end

   // --------------------
   // strobes
   // --------------------
   a_ovf: assert property (@(posedge pos_clk) disable iff (!aresetn)
      we_i && full_i |=> overflow_i && !wack_i)   // refused write
      else begin
         $error("write while full not flagged");
         fail_cnt = fail_cnt + 1;
      end
   a_udf: assert property (@(posedge pos_clk) disable iff (!aresetn)
      re_i && empty_i |=> underflow_i && !dvld_i)   // refused read
      else begin
         $error("read while empty not flagged");
         fail_cnt = fail_cnt + 1;
      end
   a_both: assert property (@(posedge pos_clk) disable iff (!aresetn)
      we_i && re_i && !full_i && !empty_i |=> $stable(level_i))
      else begin
         $error("level_o moved on write and read");
         fail_cnt = fail_cnt + 1;
      end

endmodule

`default_nettype wire

/* tests/tb_sync_fifo.sv */
// testbench for the sync fifo that runs fill, drain and mixed traffic against a queue model
`timescale 1ns/1ps
`default_nettype none

module tb_sync_fifo;

   logic                              pos_clk = 1'b0;
   logic                              aresetn;
   logic                              we;
   logic                              re;
   logic [fifo_cfg_pkg::DATA_W-1:0]   wdata;
   logic [fifo_cfg_pkg::DATA_W-1:0]   rdata;
   logic                              full;
   logic                              afull;
   logic                              empty;
   logic                              aempty;
   logic                              wack;
   logic                              dvld;
   logic                              overflow;
   logic                              underflow;
   logic [fifo_cfg_pkg::CNT_W-1:0]    level;

   int seed = 32'hd568c4ea;                          // write data stream
   logic [fifo_cfg_pkg::DATA_W-1:0] model_q [$];     // accepted words with the oldest first
   int checks    = 0;
   int errors    = 0;
   int test_cnt  = 0;
   int err_mark  = 0;   // errors at start of the current test
   int asrt_mark = 0;   // assertion failures at start of the current test
   int n_ops;

   sync_fifo u_sync_fifo (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .we_i        (we),
      .re_i        (re),
      .wdata_i     (wdata),
      .rdata_o     (rdata),
      .full_o      (full),
      .afull_o     (afull),
      .empty_o     (empty),
      .aempty_o    (aempty),
      .wack_o      (wack),
      .dvld_o      (dvld),
      .overflow_o  (overflow),
      .underflow_o (underflow),
      .level_o     (level)
   );

   // flag and strobe rules checked inside the dut scope
   bind sync_fifo sync_fifo_props u_props (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .we_i        (we_i),
      .re_i        (re_i),
      .full_i      (full_o),
      .afull_i     (afull_o),
      .empty_i     (empty_o),
      .aempty_i    (aempty_o),
      .wack_i      (wack_o),
      .dvld_i      (dvld_o),
      .overflow_i  (overflow_o),
      .underflow_i (underflow_o),
      .level_i     (level_o)
   );

   always #20 pos_clk = ~pos_clk;   // 40 ns period

   // --------------------
   // checking helpers
   // --------------------
   task automatic check_val(input string name, input int got, input int exp);
      checks++;
      assert (got == exp) else begin
         $display("error t=%0t %s got %0h expected %0h", $time, name, got, exp);
         errors++;
      end
   endtask

   // flags and level follow the model occupancy
   task automatic check_flags();
      int sz;
      sz = model_q.size();
      check_val("level_o", int'(level), sz);
      check_val("full_o", int'(full), int'(sz == fifo_cfg_pkg::DEPTH));
      check_val("empty_o", int'(empty), int'(sz == 0));
      check_val("afull_o", int'(afull), int'(sz >= int'(fifo_cfg_pkg::AFULL_VAL)));
      check_val("aempty_o", int'(aempty), int'(sz <= int'(fifo_cfg_pkg::AEMPTY_VAL)));
   endtask

   // one cycle of traffic driven 2 ns after a rising edge
   task automatic step(input bit do_wr, input bit do_rd);
      bit                              wr_acc;
      bit                              rd_acc;
      bit                              exp_ovf;
      bit                              exp_udf;
      int                              rnd;
      logic [fifo_cfg_pkg::DATA_W-1:0] exp_word;
      rnd      = $random(seed);
      wr_acc   = do_wr && (model_q.size() < fifo_cfg_pkg::DEPTH);
      rd_acc   = do_rd && (model_q.size() > 0);
      exp_ovf  = do_wr && (model_q.size() == fifo_cfg_pkg::DEPTH);
      exp_udf  = do_rd && (model_q.size() == 0);
      exp_word = '0;
      we    = do_wr;
      re    = do_rd;
      wdata = rnd[fifo_cfg_pkg::DATA_W-1:0];
      @(posedge pos_clk);
      #2;
      we = 1'b0;
      re = 1'b0;
      if (rd_acc) begin
         exp_word = model_q.pop_front();   // read sees the word before this write
      end
      if (wr_acc) begin
         model_q.push_back(wdata);
      end
      check_val("wack_o", int'(wack), int'(wr_acc));
      check_val("dvld_o", int'(dvld), int'(rd_acc));
      check_val("overflow_o", int'(overflow), int'(exp_ovf));
      check_val("underflow_o", int'(underflow), int'(exp_udf));
      if (rd_acc) begin
         check_val("rdata_o", int'(rdata), int'(exp_word));
      end
      check_flags();
   endtask

   // write until full_o within at most 40 cycles
   task automatic fill_to_full(output int n);
      n = 0;
      while (!full && n < 40) begin
         step(1'b1, 1'b0);
         n++;
      end
      if (!full) begin
         $display("timeout: full_o did not rise within 40 writes");
         errors++;
      end
   endtask

   // read until empty_o within at most 40 cycles
   task automatic drain_to_empty(output int n);
      n = 0;
      while (!empty && n < 40) begin
         step(1'b0, 1'b1);
         n++;
      end
      if (!empty) begin
         $display("timeout: empty_o did not rise within 40 reads");
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      int new_err;
      int new_asrt;
      new_err  = errors - err_mark;
      new_asrt = u_sync_fifo.u_props.fail_cnt - asrt_mark;
      test_cnt++;
      if (new_err + new_asrt == 0) begin
         $display("test %0d %s: ok", test_cnt, name);
      end else begin
         $display("test %0d %s: %0d check and %0d assertion failures",
                  test_cnt, name, new_err, new_asrt);
      end
      err_mark  = errors;
      asrt_mark = u_sync_fifo.u_props.fail_cnt;
   endtask

   // --------------------
   // stimulus
   // --------------------
   initial begin
      aresetn = 1'b0;
      we      = 1'b0;
      re      = 1'b0;
      wdata   = '0;
      repeat (10) @(posedge pos_clk);
      #2;
      aresetn = 1'b1;

      // idle values straight out of reset
      check_val("empty_o", int'(empty), 1);
      check_val("aempty_o", int'(aempty), 1);
      check_val("full_o", int'(full), 0);
      check_val("afull_o", int'(afull), 0);
      check_val("wack_o", int'(wack), 0);
      check_val("dvld_o", int'(dvld), 0);
      check_val("overflow_o", int'(overflow), 0);
      check_val("underflow_o", int'(underflow), 0);
      check_val("level_o", int'(level), 0);
      end_test("reset values");

      fill_to_full(n_ops);
      check_val("write count", n_ops, fifo_cfg_pkg::DEPTH);
      end_test("fill to full");

      step(1'b1, 1'b0);   // refused write pulses overflow
      step(1'b1, 1'b1);   // only the read goes through
      step(1'b1, 1'b0);   // back to full
      step(1'b0, 1'b0);   // strobes drop again
      end_test("write while full");

      drain_to_empty(n_ops);
      check_val("read count", n_ops, fifo_cfg_pkg::DEPTH);
      end_test("drain in order");

      step(1'b0, 1'b1);   // underflow pulse
      step(1'b1, 1'b1);   // only the write goes through
      step(1'b0, 1'b1);
      step(1'b0, 1'b0);
      end_test("read while empty");

      repeat (5) step(1'b1, 1'b0);
      repeat (20) step(1'b1, 1'b1);   // both pointers wrap here
      drain_to_empty(n_ops);
      check_val("read count", n_ops, 5);   // paired traffic leaves the first 5 words
      end_test("write and read together");

      repeat (2) @(posedge pos_clk);   // let the last assertions sample
      $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
               test_cnt, checks, errors, u_sync_fifo.u_props.fail_cnt);
      if (errors == 0 && u_sync_fifo.u_props.fail_cnt == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   // watchdog for the whole run
   initial begin
      #100us;
      $display("timeout: simulation did not finish within 100 us");
      $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

/* sync_fifo.f */
src/fifo_cfg_pkg.sv
src/fifo_state_pkg.sv
src/fifo_ctrl_if.sv
src/fifo_flag_fsm.sv
src/fifo_level_counter.sv
src/fifo_ram.sv
src/sync_fifo.sv
tests/sync_fifo_props.sv
tests/tb_sync_fifo.sv

/* run_sim.sh */
#!/bin/sh
# compile the sync fifo testbench with verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --timescale 1ns/1ps \
   --top-module tb_sync_fifo \
   -f sync_fifo.f \
   -o sim_sync_fifo || { echo "verilator build failed"; exit 1; }

out=$(./obj_dir/sim_sync_fifo +verilator+error+limit+100)
echo "$out"

echo "$out" | grep -q "^Done: no errors$" && echo "simulation passed" || {
   echo "simulation failed"
   exit 1
}
